/* hw/simd_types_pkg.sv */
// lane, word and intermediate widths
// packed lane vector types for the byte SIMD pipeline

`default_nettype none

package simd_types_pkg;

    // bits in one byte lane
    localparam int lane_width = 8;

    // lanes per word
    localparam int lane_count = 4;

    // ra, rb and result width
    localparam int word_width = 32;

    // stage-1 lane result, wide enough for a full product
    localparam int inter_width = 16;

    // single lane values
    typedef logic [lane_width-1:0] lane_t;
    typedef logic [inter_width-1:0] inter_t;

    // full word
    typedef logic [word_width-1:0] word_t;

    // lane 0 sits in the low byte
    typedef lane_t [lane_count-1:0] lane_vec_t;

    // lane 0 sits in the low half-word
    typedef inter_t [lane_count-1:0] inter_vec_t;

endpackage

`default_nettype wire

/* hw/simd_op_pkg.sv */
// lane and reduction opcode enums
// clip bounds for saturating arithmetic

`default_nettype none

package simd_op_pkg;

    // stage-1 lane operation, same in all four lanes
    typedef enum logic [3:0] {
        op_pass = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_movb = 4'd4,
        op_max  = 4'd5,
        op_min  = 4'd6,
        op_and  = 4'd7,
        op_or   = 4'd8,
        op_xor  = 4'd9,
        op_nand = 4'd10,
        op_nor  = 4'd11,
        op_xnor = 4'd12
    } lane_op_e;

    // stage-2 reduction, red_none repacks the low bytes
    typedef enum logic [2:0] {
        red_none = 3'd0,
        red_sum  = 3'd1,
        red_max  = 3'd2,
        red_min  = 3'd3,
        red_xor  = 3'd4
    } red_op_e;

    // signed byte range
    localparam int sat_smax = 127;
    localparam int sat_smin = -128;

    // unsigned byte range
    localparam int sat_umax = 255;
    localparam int sat_umin = 0;

endpackage

`default_nettype wire

/* hw/lane_mul.sv */
// lane_mul: 8x8 multiplier for one byte lane
// signed or unsigned operands, optional clip to the byte range

`default_nettype none
`timescale 1ns/100ps

module lane_mul (
    input  simd_types_pkg::lane_t  a,
    input  simd_types_pkg::lane_t  b,
    input  logic                   uns,
    input  logic                   sat,
    output simd_types_pkg::inter_t product
);
    import simd_types_pkg::*;
    import simd_op_pkg::*;

    // one extra bit so both modes go through a signed multiply
    logic signed [lane_width:0]     a_w;
    logic signed [lane_width:0]     b_w;
    logic signed [2*lane_width+1:0] full;

    assign a_w = {a[lane_width-1] & ~uns, a};
    assign b_w = {b[lane_width-1] & ~uns, b};

    // 9x9 signed product covers 255*255 as well as -128*-128
    assign full = a_w * b_w;

    always_comb begin
        product = full[inter_width-1:0];
        if (sat) begin
            if (uns) begin
                // unsigned product is never negative
                if (full > sat_umax)
                    product = inter_t'(sat_umax);
            end else begin
                if (full > sat_smax)
                    product = inter_t'(sat_smax);
                else if (full < sat_smin)
                    product = inter_t'(sat_smin);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/lane_alu.sv */
// lane_alu: stage-1 arithmetic and logic for one byte lane
// add, sub, max, min, logic, pass and movb candidates
// product taken from lane_mul, one result picked by opcode

`default_nettype none
`timescale 1ns/100ps

module lane_alu (
    input  simd_types_pkg::lane_t   a,
    input  simd_types_pkg::lane_t   b,
    input  simd_op_pkg::lane_op_e   lane_op,
    input  logic                    uns,
    input  logic                    sat,
    output simd_types_pkg::inter_t  y
);
    import simd_types_pkg::*;
    import simd_op_pkg::*;

    // operands widened by two bits, room for sum and difference
    logic signed [lane_width+1:0] a_w;
    logic signed [lane_width+1:0] b_w;
    logic signed [lane_width+1:0] sum_w;
    logic signed [lane_width+1:0] diff_w;

    lane_t  max_l;
    lane_t  min_l;
    lane_t  logic_l;

    inter_t add_y;
    inter_t sub_y;
    inter_t mul_y;
    inter_t max_y;
    inter_t min_y;
    inter_t ext_a;
    inter_t ext_b;
    inter_t logic_y;

    // sign extend when signed, zero extend otherwise
    function automatic inter_t ext_lane(input lane_t v, input logic uns_i);
        return {{(inter_width-lane_width){v[lane_width-1] & ~uns_i}}, v};
    endfunction

    // exact result kept as 16 bits unless clipping is on
    function automatic inter_t clip_byte(
        input logic signed [lane_width+1:0] v,
        input logic                         uns_i,
        input logic                         sat_i
    );
        inter_t r;
        r = {{(inter_width-lane_width-2){v[lane_width+1]}}, v};
        if (sat_i) begin
            if (uns_i) begin
                if (v > sat_umax)
                    r = inter_t'(sat_umax);
                else if (v < sat_umin)
                    r = inter_t'(sat_umin);
            end else begin
                if (v > sat_smax)
                    r = inter_t'(sat_smax);
                else if (v < sat_smin)
                    r = inter_t'(sat_smin);
            end
        end
        return r;
    endfunction

    assign a_w = {{2{a[lane_width-1] & ~uns}}, a};
    assign b_w = {{2{b[lane_width-1] & ~uns}}, b};

    assign sum_w  = a_w + b_w;
    assign diff_w = a_w - b_w;

    assign add_y = clip_byte(sum_w, uns, sat);
    assign sub_y = clip_byte(diff_w, uns, sat);

    // widened operands compare correctly in both modes
    assign max_l = (a_w > b_w) ? a : b;
    assign min_l = (a_w > b_w) ? b : a;

    assign max_y = ext_lane(max_l, uns);
    assign min_y = ext_lane(min_l, uns);
    assign ext_a = ext_lane(a, uns);
    assign ext_b = ext_lane(b, uns);

    lane_mul mul_i (
        .a       (a),
        .b       (b),
        .uns     (uns),
        .sat     (sat),
        .product (mul_y)
    );

    always_comb begin
        case (lane_op)
            op_and:  logic_l = a & b;
            op_or:   logic_l = a | b;
            op_xor:  logic_l = a ^ b;
            op_nand: logic_l = ~(a & b);
            op_nor:  logic_l = ~(a | b);
            op_xnor: logic_l = ~(a ^ b);
            default: logic_l = '0;
        endcase
    end

    // logic results never carry a sign
    assign logic_y = {{(inter_width-lane_width){1'b0}}, logic_l};

    always_comb begin
        case (lane_op)
            op_pass: y = ext_a;
            op_add:  y = add_y;
            op_sub:  y = sub_y;
            op_mul:  y = mul_y;
            op_movb: y = ext_b;
            op_max:  y = max_y;
            op_min:  y = min_y;
            op_and,
            op_or,
            op_xor,
            op_nand,
            op_nor,
            op_xnor: y = logic_y;
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/vector_reduce.sv */
// stage-2 reduction of four intermediate lanes
// sum, max, min and xor reductions plus the low-byte repack

`default_nettype none
`timescale 1ns/100ps

module vector_reduce (
    input  simd_types_pkg::inter_vec_t lanes,
    input  simd_op_pkg::red_op_e       red_op,
    input  logic                       uns,
    input  logic                       sat,
    output simd_types_pkg::word_t      y
);
    import simd_types_pkg::*;
    import simd_op_pkg::*;

    // lanes widened by one bit for signed compare and add in both modes
    logic signed [inter_width:0]   ext_l [lane_count];

    // four 17-bit values need two more bits
    logic signed [inter_width+2:0] sum_w;
    logic signed [inter_width:0]   max_w;
    logic signed [inter_width:0]   min_w;
    lane_t                         xor_l;

    word_t sum_y;
    word_t max_y;
    word_t min_y;
    word_t xor_y;
    word_t pack_y;

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            ext_l[i] = {lanes[i][inter_width-1] & ~uns, lanes[i]};
        end
    end

    always_comb begin
        sum_w = '0;
        max_w = ext_l[0];
        min_w = ext_l[0];
        xor_l = '0;
        for (int i = 0; i < lane_count; i++) begin
            sum_w = sum_w + ext_l[i];
            if (ext_l[i] > max_w)
                max_w = ext_l[i];
            if (ext_l[i] < min_w)
                min_w = ext_l[i];
            xor_l = xor_l ^ lanes[i][lane_width-1:0];
            pack_y[i*lane_width +: lane_width] = lanes[i][lane_width-1:0];
        end
    end

    // clip to the byte range or extend the exact sum
    always_comb begin
        sum_y = {{(word_width-inter_width-3){sum_w[inter_width+2]}}, sum_w};
        if (sat) begin
            if (uns) begin
                // zero-extended lanes never give a negative sum
                if (sum_w > sat_umax)
                    sum_y = word_t'(sat_umax);
            end else begin
                if (sum_w > sat_smax)
                    sum_y = word_t'(sat_smax);
                else if (sum_w < sat_smin)
                    sum_y = word_t'(sat_smin);
            end
        end
    end

    assign max_y = {{(word_width-inter_width-1){max_w[inter_width]}}, max_w};
    assign min_y = {{(word_width-inter_width-1){min_w[inter_width]}}, min_w};
    assign xor_y = {{(word_width-lane_width){1'b0}}, xor_l};

    always_comb begin
        case (red_op)
            red_sum: y = sum_y;
            red_max: y = max_y;
            red_min: y = min_y;
            red_xor: y = xor_y;
            default: y = pack_y;
        endcase
    end

endmodule

`default_nettype wire

/* hw/simd_pipe.sv */
// simd_pipe: three-stage packed-byte SIMD pipeline
// stage registers, hold control, four lane ALUs and the reducer

`default_nettype none
`timescale 1ns/100ps

module simd_pipe (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   holdn,
    input  logic                   issue,
    input  simd_types_pkg::word_t  ra,
    input  simd_types_pkg::word_t  rb,
    input  simd_op_pkg::lane_op_e  lane_op,
    input  simd_op_pkg::red_op_e   red_op,
    input  logic                   uns,
    input  logic                   sat,
    output simd_types_pkg::word_t  result,
    output logic                   result_valid
);
    import simd_types_pkg::*;
    import simd_op_pkg::*;

    // stage 1, operands and controls as issued
    lane_vec_t  s1_a;
    lane_vec_t  s1_b;
    lane_op_e   s1_op;
    red_op_e    s1_red;
    logic       s1_uns;
    logic       s1_sat;
    logic       s1_valid;

    // stage 2, intermediate lanes
    inter_vec_t s2_lanes;
    red_op_e    s2_red;
    logic       s2_uns;
    logic       s2_sat;
    logic       s2_valid;

    // stage 3, final word
    word_t      s3_result;
    logic       s3_valid;

    inter_vec_t alu_y;
    word_t      red_y;

    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        lane_alu alu_i (
            .a       (s1_a[g]),
            .b       (s1_b[g]),
            .lane_op (s1_op),
            .uns     (s1_uns),
            .sat     (s1_sat),
            .y       (alu_y[g])
        );
    end

    vector_reduce reduce_i (
        .lanes  (s2_lanes),
        .red_op (s2_red),
        .uns    (s2_uns),
        .sat    (s2_sat),
        .y      (red_y)
    );

    // all stages move together, a low holdn freezes everything
    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_a      <= '0;
            s1_b      <= '0;
            s1_op     <= op_pass;
            s1_red    <= red_none;
            s1_uns    <= 1'b0;
            s1_sat    <= 1'b0;
            s1_valid  <= 1'b0;
            s2_lanes  <= '0;
            s2_red    <= red_none;
            s2_uns    <= 1'b0;
            s2_sat    <= 1'b0;
            s2_valid  <= 1'b0;
            s3_result <= '0;
            s3_valid  <= 1'b0;
        end else if (holdn) begin
            s1_a      <= ra;
            s1_b      <= rb;
            s1_op     <= lane_op;
            s1_red    <= red_op;
            s1_uns    <= uns;
            s1_sat    <= sat;
            s1_valid  <= issue;
            s2_lanes  <= alu_y;
            s2_red    <= s1_red;
            s2_uns    <= s1_uns;
            s2_sat    <= s1_sat;
            s2_valid  <= s1_valid;
            s3_result <= red_y;
            s3_valid  <= s2_valid;
        end
    end

    assign result       = s3_result;
    assign result_valid = s3_valid;

endmodule

`default_nettype wire

/* tb/simd_pipe_tb.sv */
// testbench for the packed-byte SIMD pipeline
// lane and reduction model, directed tests, timeout and report

`default_nettype none
`timescale 1ns/100ps

module simd_pipe_tb;
    import simd_types_pkg::*;
    import simd_op_pkg::*;

    localparam int max_cycles = 2000;

    logic     clk;
    logic     rstn;
    logic     holdn;
    logic     issue;
    word_t    ra;
    word_t    rb;
    lane_op_e lane_op;
    red_op_e  red_op;
    logic     uns;
    logic     sat;
    word_t    result;
    logic     result_valid;

    int seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    simd_pipe dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .holdn        (holdn),
        .issue        (issue),
        .ra           (ra),
        .rb           (rb),
        .lane_op      (lane_op),
        .red_op       (red_op),
        .uns          (uns),
        .sat          (sat),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic int byte_value(input lane_t v, input logic u);
        return u ? int'(v) : int'($signed(v));
    endfunction

    function automatic int half_value(input inter_t v, input logic u);
        return u ? int'(v) : int'($signed(v));
    endfunction

    function automatic int clip_value(input int v, input logic u, input logic s);
        int hi;
        int lo;
        if (!s)
            return v;
        hi = u ? 255 : 127;
        lo = u ? 0 : -128;
        return (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    function automatic inter_t expect_lane(input lane_t a, input lane_t b, input lane_op_e op,
                                           input logic u, input logic s);
        int x;
        int y;
        int r;
        lane_t bits;
        x = byte_value(a, u);
        y = byte_value(b, u);
        bits = '0;
        case (op)
            op_pass: r = x;
            op_add:  r = clip_value(x + y, u, s);
            op_sub:  r = clip_value(x - y, u, s);
            op_mul:  r = clip_value(x * y, u, s);
            op_movb: r = y;
            op_max:  r = (x > y) ? x : y;
            op_min:  r = (x < y) ? x : y;
            default: begin
                case (op)
                    op_and:  bits = a & b;
                    op_or:   bits = a | b;
                    op_xor:  bits = a ^ b;
                    op_nand: bits = ~(a & b);
                    op_nor:  bits = ~(a | b);
                    op_xnor: bits = ~(a ^ b);
                    default: bits = '0;
                endcase
                // logic lanes always zero extended
                r = int'(bits);
            end
        endcase
        return inter_t'(r);
    endfunction

    function automatic word_t expect_word(input word_t a, input word_t b, input lane_op_e op,
                                          input red_op_e rop, input logic u, input logic s);
        inter_t l [4];
        int v [4];
        int acc;
        int hi;
        int lo;
        lane_t x;
        word_t w;
        int i;
        for (i = 0; i < 4; i++) begin
            l[i] = expect_lane(a[8*i +: 8], b[8*i +: 8], op, u, s);
            v[i] = half_value(l[i], u);
        end
        acc = 0;
        hi = v[0];
        lo = v[0];
        x = '0;
        w = '0;
        for (i = 0; i < 4; i++) begin
            acc = acc + v[i];
            if (v[i] > hi)
                hi = v[i];
            if (v[i] < lo)
                lo = v[i];
            x = x ^ l[i][7:0];
            w[8*i +: 8] = l[i][7:0];
        end
        case (rop)
            red_sum: return word_t'(clip_value(acc, u, s));
            red_max: return word_t'(hi);
            red_min: return word_t'(lo);
            red_xor: return {24'b0, x};
            default: return w;
        endcase
    endfunction

    // single issue followed by a wait for result_valid and a value and latency check
    task automatic check_op(input string name, input word_t a, input word_t b,
                            input lane_op_e lop, input red_op_e rop, input logic u,
                            input logic s);
        word_t exp;
        int n;
        exp = expect_word(a, b, lop, rop, u, s);
        ra = a;
        rb = b;
        lane_op = lop;
        red_op = rop;
        uns = u;
        sat = s;
        issue = 1'b1;
        step();
        issue = 1'b0;
        // the sampling edge is the first edge after the issue
        n = 1;
        while (!result_valid && n < 8) begin
            step();
            n++;
        end
        checks++;
        if (!result_valid) begin
            errors++;
            $display("%s: no valid result within 8 cycles of the issue", name);
        end else begin
            if (n != 3) begin
                errors++;
                $display("%s: result came %0d edges after the issue, not 3", name, n);
            end
            if (result !== exp) begin
                errors++;
                $display("ERR %s: expected %h, actual %h", name, exp, result);
            end
        end
    endtask

    task automatic check_quiet(input string name, input logic want_zero);
        checks++;
        if (result_valid !== 1'b0) begin
            errors++;
            $display("ERR %s: expected result_valid 0, actual %b", name, result_valid);
        end
        if (want_zero && result !== '0) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, 32'h0, result);
        end
    endtask

    task automatic add_sub_test();
        word_t a;
        word_t b;
        int u;
        int s;
        for (u = 0; u < 2; u++) begin
            for (s = 0; s < 2; s++) begin
                // lanes 100+100, 10-20, 127+1, -128+-128
                a = 32'h807f0a64;
                b = 32'h80011464;
                check_op($sformatf("add u%0d s%0d", u, s), a, b, op_add, red_none, u[0], s[0]);
                check_op($sformatf("sub u%0d s%0d", u, s), a, b, op_sub, red_none, u[0], s[0]);
                a = $random(seed);
                b = $random(seed);
                check_op($sformatf("add rnd u%0d s%0d", u, s), a, b, op_add, red_none,
                         u[0], s[0]);
                check_op($sformatf("sub rnd u%0d s%0d", u, s), a, b, op_sub, red_none,
                         u[0], s[0]);
            end
        end
    endtask

    task automatic mul_test();
        int u;
        int s;
        int k;
        for (u = 0; u < 2; u++) begin
            for (s = 0; s < 2; s++) begin
                // -128*127, 255*255, 127*127, -128*-128
                check_op($sformatf("mul ext u%0d s%0d", u, s), 32'h807fff80, 32'h807fff7f,
                         op_mul, red_none, u[0], s[0]);
                for (k = 0; k < 2; k++)
                    check_op($sformatf("mul rnd u%0d s%0d", u, s), $random(seed),
                             $random(seed), op_mul, red_none, u[0], s[0]);
            end
        end
    endtask

    task automatic lane_op_test();
        lane_op_e op;
        int u;
        int i;
        for (u = 0; u < 2; u++) begin
            for (i = 0; i < 13; i++) begin
                op = lane_op_e'(i);
                if (op != op_add && op != op_sub && op != op_mul) begin
                    check_op($sformatf("%s u%0d", op.name(), u), 32'h807ff005, 32'h01fe0f85,
                             op, red_none, u[0], 1'b0);
                    check_op($sformatf("%s rnd u%0d", op.name(), u), $random(seed),
                             $random(seed), op, red_none, u[0], 1'b0);
                end
            end
        end
    endtask

    task automatic reduce_test();
        lane_op_e lop;
        red_op_e rop;
        int u;
        int k;
        int r;
        for (u = 0; u < 2; u++) begin
            for (k = 0; k < 2; k++) begin
                lop = (k == 0) ? op_add : op_pass;
                // index 1 is the saturating sum
                for (r = 0; r < 5; r++) begin
                    rop = (r < 2) ? red_sum : red_op_e'(r);
                    check_op($sformatf("%s %s s%0d u%0d", lop.name(), rop.name(), r == 1, u),
                             $random(seed), $random(seed), lop, rop, u[0], r == 1);
                end
            end
        end
    endtask

    // back-to-back issues, a five-cycle hold mid-stream, then more issues
    task automatic pipeline_test();
        word_t exp_q [$];
        int edge_q [$];
        int hold_q [$];
        int hold_total;
        int valid_count;
        int issued;
        int due;
        int t;
        int rnd;
        logic do_hold;
        logic last_valid;
        word_t last_result;
        word_t exp;
        hold_total = 0;
        valid_count = 0;
        issued = 0;
        last_valid = result_valid;
        last_result = result;
        for (t = 0; t < 22; t++) begin
            do_hold = (t >= 6 && t < 11);
            holdn = !do_hold;
            issue = (t < 6) || (t >= 11 && t < 14);
            if (issue) begin
                rnd = $random(seed);
                ra = $random(seed);
                rb = $random(seed);
                lane_op = lane_op_e'({$random(seed)} % 13);
                red_op = red_op_e'({$random(seed)} % 5);
                uns = rnd[0];
                sat = rnd[1];
                exp_q.push_back(expect_word(ra, rb, lane_op, red_op, uns, sat));
                // edge count at the time the issue is driven
                edge_q.push_back(cycles);
                hold_q.push_back(hold_total);
                issued++;
            end
            step();
            if (do_hold) begin
                hold_total++;
                checks++;
                if (result !== last_result || result_valid !== last_valid) begin
                    errors++;
                    $display("ERR pipeline hold: expected %h, actual %h", last_result, result);
                end
            end else if (result_valid) begin
                valid_count++;
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("pipeline: result_valid high with no issue in flight");
                end else begin
                    exp = exp_q.pop_front();
                    due = edge_q.pop_front() + 3 + hold_total - hold_q.pop_front();
                    if (cycles != due) begin
                        errors++;
                        $display("pipeline: result came at cycle %0d, not %0d", cycles, due);
                    end
                    if (result !== exp) begin
                        errors++;
                        $display("ERR pipeline: expected %h, actual %h", exp, result);
                    end
                end
            end
            last_valid = result_valid;
            last_result = result;
        end
        holdn = 1'b1;
        issue = 1'b0;
        if (valid_count != issued) begin
            errors++;
            $display("pipeline: %0d valid results for %0d issues", valid_count, issued);
        end
    endtask

    initial begin
        seed = 32'h30899b88;
        rstn = 1'b0;
        holdn = 1'b1;
        issue = 1'b0;
        ra = '0;
        rb = '0;
        lane_op = op_pass;
        red_op = red_none;
        uns = 1'b0;
        sat = 1'b0;
        repeat (10) begin
            step();
            check_quiet("reset", 1'b1);
        end
        rstn = 1'b1;
        repeat (4) begin
            step();
            check_quiet("after reset", 1'b1);
        end
        add_sub_test();
        mul_test();
        lane_op_test();
        reduce_test();
        pipeline_test();
        // idle cycles give no valid result
        repeat (4) begin
            step();
            check_quiet("idle", 1'b0);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/simd_types_pkg.sv
hw/simd_op_pkg.sv
hw/lane_mul.sv
hw/lane_alu.sv
hw/vector_reduce.sv
hw/simd_pipe.sv
tb/simd_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SIMD pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module simd_pipe_tb -f sources.f -o simd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/simd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1
